//--- flist.f
+incdir+testbench
rtl/tracker_pkg.sv
rtl/pixel_stream_if.sv
rtl/red_pixel_detector.sv
rtl/centroid_accumulator.sv
rtl/crosshair_overlay.sv
rtl/stream_fifo.sv
rtl/red_tracker_top.sv
testbench/tb_red_tracker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_red_tracker
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/1ns

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# passes only when the pass line shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// strong red byte, green and blue both weak
function automatic bit classify_red(input logic [31:0] word);
    return (word[23:16] >= RED_MIN) && (word[15:8] < OTHER_MAX) && (word[7:0] < OTHER_MAX);
endfunction

// either arm of the cross, positions outside the frame never occur
function automatic bit on_crosshair(input int x, input int y, input int cx, input int cy);
    int dx;
    int dy;
    dx = (x > cx) ? x - cx : cx - x;
    dy = (y > cy) ? y - cy : cy - y;
    return ((x == cx) && (dy <= CROSSHAIR_SIZE)) || ((y == cy) && (dx <= CROSSHAIR_SIZE));
endfunction

// mean position of the red pixels, rounded down
function automatic void find_centroid(input logic [31:0] pix [IMG_WIDTH * IMG_HEIGHT],
                                      output int cx, output int cy, output bit found);
    int cnt;
    int sx;
    int sy;
    cnt = 0;
    sx = 0;
    sy = 0;
    for (int i = 0; i < IMG_WIDTH * IMG_HEIGHT; i++) begin
        if (classify_red(pix[i])) begin
            cnt++;
            sx += i % IMG_WIDTH;
            sy += i / IMG_WIDTH;
        end
    end
    found = (cnt >= PIXEL_THRESHOLD);
    cx = found ? sx / cnt : 0;
    cy = found ? sy / cnt : 0;
endfunction

`endif

//--- testbench/tb_red_tracker.sv
`timescale 1ns/1ns

module tb_red_tracker;
    import tracker_pkg::*;

    `include "tb_frame_model.svh"

    localparam int NPIX    = IMG_WIDTH * IMG_HEIGHT;
    localparam int TIMEOUT = 200;   // cycles per wait

    logic        i_clk = 1'b0;
    logic        i_reset;
    pixel_t      i_tdata;
    logic        i_tvalid;
    logic        o_tready;
    logic        i_tuser;
    logic        i_tlast;
    pixel_t      o_tdata;
    logic        o_tvalid;
    logic        i_tready;
    logic        o_tuser;
    logic        o_tlast;

    logic [31:0] frame_buf [NPIX];
    logic [33:0] exp_q [$];          // {eol, sof, word}
    bit          stall_mode;
    bit          tready_low_seen;
    int          prev_cx;
    int          prev_cy;
    bit          prev_found;
    int          wait_cnt;

    red_tracker_top DUT (.*);

    always #50 i_clk = ~i_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // random sink stalls while back-pressure runs
    always @(negedge i_clk) begin
        i_tready = stall_mode ? (($urandom % 2) == 1) : 1'b1;
    end

    // scoreboard on every output transfer
    always @(posedge i_clk) begin
        logic [33:0] head;
        if (!i_reset && o_tready === 1'b0) tready_low_seen = 1'b1;
        if (!i_reset && o_tvalid && i_tready) begin
            assert (exp_q.size() > 0) else report_failure("output beat arrived with none expected");
            head = exp_q.pop_front();
            assert (o_tdata == head[31:0]) else report_failure(
                $sformatf("FAIL o_tdata got %08h expected %08h", o_tdata, head[31:0]));
            assert (o_tuser == head[32]) else report_failure(
                $sformatf("FAIL o_tuser got %0h expected %0h", o_tuser, head[32]));
            assert (o_tlast == head[33]) else report_failure(
                $sformatf("FAIL o_tlast got %0h expected %0h", o_tlast, head[33]));
        end
    end

    // never red and unique per position
    task automatic fill_background(input int frame_no);
        for (int i = 0; i < NPIX; i++) begin
            frame_buf[i] = {8'h00, 8'(i % IMG_WIDTH * 8), 8'(i / IMG_WIDTH * 16 + frame_no), 8'h55};
        end
    endtask

    task automatic paint_rect(input int x0, input int y0, input int x1, input int y1,
                              input logic [31:0] word);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                frame_buf[y * IMG_WIDTH + x] = word;
            end
        end
    endtask

    // queue the expected frame, commit its centroid, then drive its beats
    task automatic send_frame(input bit gaps);
        int  cx;
        int  cy;
        bit  found;
        for (int i = 0; i < NPIX; i++) begin
            exp_q.push_back({(i % IMG_WIDTH) == IMG_WIDTH - 1, i == 0,
                (prev_found && on_crosshair(i % IMG_WIDTH, i / IMG_WIDTH, prev_cx, prev_cy)) ?
                CROSSHAIR_COLOR : frame_buf[i]});
        end
        find_centroid(frame_buf, cx, cy, found);
        prev_cx = cx;
        prev_cy = cy;
        prev_found = found;
        for (int i = 0; i < NPIX; i++) begin
            @(negedge i_clk);
            if (gaps && ($urandom % 4) == 0) begin
                i_tvalid = 1'b0;
                @(negedge i_clk);
            end
            i_tvalid = 1'b1;
            i_tdata  = frame_buf[i];
            i_tuser  = (i == 0);
            i_tlast  = (i % IMG_WIDTH) == IMG_WIDTH - 1;
            wait_cnt = 0;
            while (o_tready !== 1'b1 && wait_cnt < TIMEOUT) begin
                @(negedge i_clk);
                wait_cnt++;
            end
            assert (o_tready === 1'b1) else report_failure("input beat not accepted in time");
        end
        @(negedge i_clk);
        i_tvalid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h285e));
        i_reset         = 1'b1;
        i_tvalid        = 1'b0;
        i_tdata         = '0;
        i_tuser         = 1'b0;
        i_tlast         = 1'b0;
        i_tready        = 1'b1;
        stall_mode      = 1'b0;
        tready_low_seen = 1'b0;
        prev_found      = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        assert (o_tvalid == 1'b0) else report_failure(
            $sformatf("FAIL o_tvalid got %0h expected 0", o_tvalid));
        assert (o_tready == 1'b1) else report_failure(
            $sformatf("FAIL o_tready got %0h expected 1", o_tready));

        fill_background(0);                       // plain frame passes unchanged
        send_frame(1'b0);
        fill_background(1);
        paint_rect(5, 3, 8, 5, 32'h00E01020);
        paint_rect(15, 11, 15, 11, 32'h00C03F3F); // weakest red word pulls the centre right
        paint_rect(0, 11, 0, 11, 32'h00FF4000);   // green at the limit would pull it left
        send_frame(1'b0);
        fill_background(2);                       // crosshair of the rectangle
        paint_rect(0, 10, 1, 11, 32'h00FF0000);   // corner object exactly at threshold
        send_frame(1'b0);
        fill_background(3);                       // clipped crosshair and only three red
        paint_rect(13, 1, 15, 1, 32'h00F00000);
        send_frame(1'b0);
        fill_background(4);                       // nothing to draw
        send_frame(1'b0);

        stall_mode = 1'b1;
        fill_background(5);
        paint_rect(10, 7, 14, 8, 32'h00D02010);
        send_frame(1'b1);
        fill_background(6);
        for (int i = 0; i < NPIX; i++) begin
            if (($urandom % 6) == 0) frame_buf[i] = {8'h00, 8'hC0 + 8'($urandom % 64), 16'h0010};
        end
        send_frame(1'b1);
        fill_background(7);                       // shows the centroid of the scattered reds
        send_frame(1'b0);

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 4 * TIMEOUT) begin
            @(negedge i_clk);
            wait_cnt++;
        end
        assert (tready_low_seen) else report_failure("o_tready never dropped under back-pressure");
        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure("output stream did not drain in time");
        end
    end

endmodule

//--- rtl/red_tracker_top.sv
`timescale 1ns/1ns

module red_tracker_top (
    input  logic                i_clk,
    input  logic                i_reset,

    // raw pixel stream in
    input  tracker_pkg::pixel_t i_tdata,
    input  logic                i_tvalid,
    output logic                o_tready,
    input  logic                i_tuser,   // start of frame
    input  logic                i_tlast,   // end of line

    // overlaid stream toward the video DMA
    output tracker_pkg::pixel_t o_tdata,
    output logic                o_tvalid,
    input  logic                i_tready,
    output logic                o_tuser,
    output logic                o_tlast
);
    import tracker_pkg::*;

    pixel_stream_if det_to_ovl ();
    pixel_stream_if ovl_to_fifo ();

    logic           det_red_flag;
    logic [X_W-1:0] cen_x;
    logic [Y_W-1:0] cen_y;
    logic           cen_valid;
    logic           frame_done;

    red_pixel_detector u_detector (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tdata    (i_tdata),
        .i_tvalid   (i_tvalid),
        .o_tready   (o_tready),
        .i_tuser    (i_tuser),
        .i_tlast    (i_tlast),
        .out        (det_to_ovl.source),
        .o_red_flag (det_red_flag)
    );

    // watches the same hop the overlay consumes
    centroid_accumulator u_centroid (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .mon          (det_to_ovl.monitor),
        .i_red_flag   (det_red_flag),
        .o_cen_x      (cen_x),
        .o_cen_y      (cen_y),
        .o_cen_valid  (cen_valid),
        .o_frame_done (frame_done)
    );

    crosshair_overlay u_overlay (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .in           (det_to_ovl.sink),
        .i_cen_x      (cen_x),
        .i_cen_y      (cen_y),
        .i_cen_valid  (cen_valid),
        .i_frame_done (frame_done),
        .out          (ovl_to_fifo.source)
    );

    stream_fifo u_out_fifo (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .in       (ovl_to_fifo.sink),
        .o_tdata  (o_tdata),
        .o_tvalid (o_tvalid),
        .i_tready (i_tready),
        .o_tuser  (o_tuser),
        .o_tlast  (o_tlast)
    );

endmodule

//--- rtl/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo (
    input  logic                i_clk,
    input  logic                i_reset,
    pixel_stream_if.sink        in,
    output tracker_pkg::pixel_t o_tdata,
    output logic                o_tvalid,
    input  logic                i_tready,
    output logic                o_tuser,
    output logic                o_tlast
);
    import tracker_pkg::*;

    pixel_t                mem_pix [FIFO_DEPTH];
    logic                  mem_sof [FIFO_DEPTH];
    logic                  mem_eol [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign in.ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign wr_en    = in.valid && in.ready;

    // pop into the output register when it is empty or being taken
    assign rd_en = (count != '0) && (!o_tvalid || i_tready);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr   <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                o_tvalid <= 1'b1;
            end else if (i_tready) begin
                o_tvalid <= 1'b0;
            end
            count <= count + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(rd_en);
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_pix[wr_ptr] <= in.pixel;
            mem_sof[wr_ptr] <= in.sof;
            mem_eol[wr_ptr] <= in.eol;
        end
        if (rd_en) begin
            o_tdata <= mem_pix[rd_ptr];
            o_tuser <= mem_sof[rd_ptr];
            o_tlast <= mem_eol[rd_ptr];
        end
    end

endmodule

//--- rtl/crosshair_overlay.sv
`timescale 1ns/1ns

module crosshair_overlay (
    input  logic                        i_clk,
    input  logic                        i_reset,
    pixel_stream_if.sink                in,
    input  logic [tracker_pkg::X_W-1:0] i_cen_x,
    input  logic [tracker_pkg::Y_W-1:0] i_cen_y,
    input  logic                        i_cen_valid,
    input  logic                        i_frame_done,
    pixel_stream_if.source              out
);
    import tracker_pkg::*;

    logic           xfer;
    logic [X_W-1:0] x_cnt;
    logic [Y_W-1:0] y_cnt;
    logic [X_W-1:0] cur_x;
    logic [Y_W-1:0] cur_y;
    logic [X_W-1:0] pend_x;
    logic [Y_W-1:0] pend_y;
    logic           pend_valid;
    logic [X_W-1:0] pend_x_nxt;
    logic [Y_W-1:0] pend_y_nxt;
    logic           pend_valid_nxt;
    logic [X_W-1:0] act_x;
    logic [Y_W-1:0] act_y;
    logic           act_valid;
    logic [X_W-1:0] use_x;
    logic [Y_W-1:0] use_y;
    logic           use_valid;
    logic [X_W-1:0] dx;
    logic [Y_W-1:0] dy;
    logic           paint;

    assign in.ready = !out.valid || out.ready;
    assign xfer     = in.valid && in.ready;

    assign cur_x = in.sof ? '0 : x_cnt;
    assign cur_y = in.sof ? '0 : y_cnt;

    // frame_done can coincide with the next sof, so bypass into pending
    assign pend_x_nxt     = i_frame_done ? i_cen_x : pend_x;
    assign pend_y_nxt     = i_frame_done ? i_cen_y : pend_y;
    assign pend_valid_nxt = i_frame_done ? i_cen_valid : pend_valid;

    // sof beat already uses the newly adopted centroid
    assign use_x     = in.sof ? pend_x_nxt : act_x;
    assign use_y     = in.sof ? pend_y_nxt : act_y;
    assign use_valid = in.sof ? pend_valid_nxt : act_valid;

    assign dx = (cur_x >= use_x) ? cur_x - use_x : use_x - cur_x;
    assign dy = (cur_y >= use_y) ? cur_y - use_y : use_y - cur_y;

    // vertical arm or horizontal arm, edges clip naturally
    assign paint = use_valid &&
                   (((cur_x == use_x) && (dy <= Y_W'(CROSSHAIR_SIZE))) ||
                    ((cur_y == use_y) && (dx <= X_W'(CROSSHAIR_SIZE))));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            out.valid  <= 1'b0;
            x_cnt      <= '0;
            y_cnt      <= '0;
            pend_valid <= 1'b0;
            act_valid  <= 1'b0;
        end else begin
            pend_valid <= pend_valid_nxt;
            if (xfer) begin
                out.valid <= 1'b1;
                act_valid <= use_valid;
                x_cnt     <= in.eol ? '0 : cur_x + 1'b1;
                y_cnt     <= in.eol ? cur_y + 1'b1 : cur_y;
            end else if (out.ready) begin
                out.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        pend_x <= pend_x_nxt;
        pend_y <= pend_y_nxt;
        if (xfer) begin
            act_x         <= use_x;
            act_y         <= use_y;
            out.pixel.raw <= paint ? CROSSHAIR_COLOR : in.pixel.raw;
            out.sof       <= in.sof;
            out.eol       <= in.eol;
        end
    end

endmodule

//--- rtl/centroid_accumulator.sv
`timescale 1ns/1ns

module centroid_accumulator (
    input  logic                       i_clk,
    input  logic                       i_reset,
    pixel_stream_if.monitor            mon,
    input  logic                       i_red_flag,
    output logic [tracker_pkg::X_W-1:0] o_cen_x,
    output logic [tracker_pkg::Y_W-1:0] o_cen_y,
    output logic                       o_cen_valid,
    output logic                       o_frame_done
);
    import tracker_pkg::*;

    logic               xfer;
    logic               red_hit;
    logic               frame_end;
    logic [X_W-1:0]     x_cnt;
    logic [Y_W-1:0]     y_cnt;
    logic [X_W-1:0]     cur_x;
    logic [Y_W-1:0]     cur_y;
    logic [CNT_W-1:0]   red_cnt;
    logic [SUM_X_W-1:0] sum_x;
    logic [SUM_Y_W-1:0] sum_y;
    logic [CNT_W-1:0]   cnt_nxt;
    logic [SUM_X_W-1:0] sum_x_nxt;
    logic [SUM_Y_W-1:0] sum_y_nxt;
    logic [SUM_X_W-1:0] quot_x;
    logic [SUM_Y_W-1:0] quot_y;

    assign xfer    = mon.valid && mon.ready;
    assign red_hit = xfer && i_red_flag;

    // position of the beat on the hop, sof restarts at the origin
    assign cur_x = mon.sof ? '0 : x_cnt;
    assign cur_y = mon.sof ? '0 : y_cnt;

    assign frame_end = xfer && mon.eol && (cur_y == Y_W'(IMG_HEIGHT - 1));

    // running totals including the current beat
    assign cnt_nxt   = (mon.sof ? '0 : red_cnt) + CNT_W'(red_hit);
    assign sum_x_nxt = (mon.sof ? '0 : sum_x) + (red_hit ? SUM_X_W'(cur_x) : '0);
    assign sum_y_nxt = (mon.sof ? '0 : sum_y) + (red_hit ? SUM_Y_W'(cur_y) : '0);

    // floor division, only used once count clears the threshold
    assign quot_x = sum_x_nxt / SUM_X_W'(cnt_nxt);
    assign quot_y = sum_y_nxt / SUM_Y_W'(cnt_nxt);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            x_cnt        <= '0;
            y_cnt        <= '0;
            red_cnt      <= '0;
            sum_x        <= '0;
            sum_y        <= '0;
            o_cen_valid  <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= frame_end;
            if (xfer) begin
                red_cnt <= cnt_nxt;
                sum_x   <= sum_x_nxt;
                sum_y   <= sum_y_nxt;
                if (mon.eol) begin
                    x_cnt <= '0;
                    y_cnt <= cur_y + 1'b1;
                end else begin
                    x_cnt <= cur_x + 1'b1;
                    y_cnt <= cur_y;
                end
            end
            if (frame_end) begin
                o_cen_valid <= (cnt_nxt >= CNT_W'(PIXEL_THRESHOLD));
            end
        end
    end

    // coordinates only move on a valid object, otherwise the old ones stay
    always_ff @(posedge i_clk) begin
        if (frame_end && (cnt_nxt >= CNT_W'(PIXEL_THRESHOLD))) begin
            o_cen_x <= quot_x[X_W-1:0];
            o_cen_y <= quot_y[Y_W-1:0];
        end
    end

endmodule

//--- rtl/red_pixel_detector.sv
`timescale 1ns/1ns

module red_pixel_detector (
    input  logic                i_clk,
    input  logic                i_reset,
    input  tracker_pkg::pixel_t i_tdata,
    input  logic                i_tvalid,
    output logic                o_tready,
    input  logic                i_tuser,
    input  logic                i_tlast,
    pixel_stream_if.source      out,
    output logic                o_red_flag
);
    import tracker_pkg::*;

    logic accept;
    logic is_red;

    // single register stage, free when empty or draining this cycle
    assign o_tready = !out.valid || out.ready;
    assign accept   = i_tvalid && o_tready;

    // strong red channel with weak green and blue
    assign is_red = (i_tdata.ch.red >= RED_MIN) &&
                    (i_tdata.ch.green < OTHER_MAX) &&
                    (i_tdata.ch.blue < OTHER_MAX);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            out.valid <= 1'b0;
        end else begin
            if (accept) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;   // beat left, nothing new
            end
        end
    end

    // beat payload, red flag travels alongside
    always_ff @(posedge i_clk) begin
        if (accept) begin
            out.pixel  <= i_tdata;
            out.sof    <= i_tuser;
            out.eol    <= i_tlast;
            o_red_flag <= is_red;
        end
    end

endmodule

//--- rtl/pixel_stream_if.sv
`timescale 1ns/1ns

interface pixel_stream_if;
    import tracker_pkg::*;

    logic   valid;
    logic   ready;
    pixel_t pixel;
    logic   sof;     // start of frame
    logic   eol;     // end of line

    modport source (
        output valid, pixel, sof, eol,
        input  ready
    );

    modport sink (
        input  valid, pixel, sof, eol,
        output ready
    );

    // observes transfers, never stalls the hop
    modport monitor (
        input valid, ready, pixel, sof, eol
    );

endinterface

//--- rtl/tracker_pkg.sv
package tracker_pkg;

    // frame geometry, kept small for simulation
    localparam int IMG_WIDTH  = 16;
    localparam int IMG_HEIGHT = 12;

    // coordinate and accumulator widths
    localparam int X_W     = 4;
    localparam int Y_W     = 4;
    localparam int CNT_W   = 8;   // up to 192 red pixels per frame
    localparam int SUM_X_W = 12;
    localparam int SUM_Y_W = 12;

    // object detection and crosshair
    localparam int PIXEL_THRESHOLD = 4;
    localparam int CROSSHAIR_SIZE  = 2;   // arm length each side of centre

    // red classification bounds
    localparam logic [7:0] RED_MIN   = 8'hC0;
    localparam logic [7:0] OTHER_MAX = 8'h40;

    localparam logic [31:0] CROSSHAIR_COLOR = 32'h0000FF00;  // pure green

    // output buffer
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // one raw word as carried on the streams, or split into channels
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0] pad;
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } ch;
    } pixel_t;

endpackage
